//--- build.f
hdl/soc_ctrl_pkg.sv
hdl/llc_event_counters.sv
hdl/soc_ctrl_regs.sv
hdl/soc_ctrl_top.sv
tb/soc_ctrl_properties.sv
tb/soc_ctrl_tb.sv

//--- hdl/llc_event_counters.sv
/* four wrapping LLC event counters, cleared only by reset
   an event is counted in any cycle where count_en_i is high */
`timescale 1ns/1ps

module llc_event_counters (
   input  logic                      clk_i,
   input  logic                      reset_i,
   input  logic                      count_en_i,
   input  soc_ctrl_pkg::llc_events_t events_i,
   output soc_ctrl_pkg::llc_counts_t counts_o
);
   import soc_ctrl_pkg::*;

   // element i of each packed view lines up with the same event
   logic       [NUM_LLC_EVENTS-1:0] ev;
   llc_count_t [NUM_LLC_EVENTS-1:0] cnt_d;
   llc_count_t [NUM_LLC_EVENTS-1:0] cnt_q;

   assign ev = events_i;

   always_comb begin
      cnt_d = cnt_q;
      for (int i = 0; i < NUM_LLC_EVENTS; i++) begin
         if (count_en_i && ev[i]) begin
            // overflow wraps modulo 2^32
            cnt_d[i] = cnt_q[i] + llc_count_t'(1);
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         cnt_q <= '0;
      end else begin
         cnt_q <= cnt_d;
      end
   end

   // same packed layout as llc_counts_t, so field order follows the events
   assign counts_o = cnt_q;

endmodule

//--- hdl/soc_ctrl_pkg.sv
/* shared types, register map and reset values of the SoC control block
   only address bits 7:2 select a register, and every access is a full 32-bit word */
package soc_ctrl_pkg;

   // bus and counter widths
   localparam int unsigned APB_ADDR_W     = 32;
   localparam int unsigned DATA_W         = 32;
   localparam int unsigned COUNT_W        = 32;
   localparam int unsigned CLK_SEL_W      = 2;
   localparam int unsigned NUM_LLC_EVENTS = 4;

   // the word index is taken from these address bits
   localparam int unsigned REG_IDX_LSB = 2;
   localparam int unsigned REG_IDX_W   = 6;

   typedef logic [APB_ADDR_W-1:0] apb_addr_t;
   typedef logic [DATA_W-1:0]     reg_data_t;
   typedef logic [COUNT_W-1:0]    llc_count_t;
   typedef logic [CLK_SEL_W-1:0]  clk_sel_t;
   typedef logic [REG_IDX_W-1:0]  reg_idx_t;

   // register map as byte offsets
   localparam apb_addr_t CTRL_CLUSTER_OFS    = 32'h00;
   localparam apb_addr_t LLC_CACHE_START_OFS = 32'h04;
   localparam apb_addr_t LLC_CACHE_END_OFS   = 32'h08;
   localparam apb_addr_t LLC_SPM_START_OFS   = 32'h0C;
   localparam apb_addr_t LLC_CNT_EN_OFS      = 32'h10;
   localparam apb_addr_t CLK_SEL_OFS         = 32'h14;
   localparam apb_addr_t CLK_DIV_OFS         = 32'h18;
   localparam apb_addr_t CLK_GATE_OFS        = 32'h1C;
   // counters are read only and a write to them is answered with pslverr
   localparam apb_addr_t READ_HIT_OFS        = 32'h20;
   localparam apb_addr_t READ_MISS_OFS       = 32'h24;
   localparam apb_addr_t WRITE_HIT_OFS       = 32'h28;
   localparam apb_addr_t WRITE_MISS_OFS      = 32'h2C;

   // bit positions inside the narrow registers
   localparam int unsigned CLUSTER_RESET_N_BIT    = 0;
   localparam int unsigned CLUSTER_EN_SA_BOOT_BIT = 1;
   localparam int unsigned CLUSTER_FETCH_EN_BIT   = 2;
   localparam int unsigned CNT_EN_BIT             = 0;
   localparam int unsigned CLK_GATE_EN_BIT        = 0;

   typedef struct packed {
      apb_addr_t paddr;
      logic      psel;
      logic      penable;
      logic      pwrite;
      reg_data_t pwdata;
   } apb_req_t;

   typedef struct packed {
      reg_data_t prdata;
      logic      pready;
      logic      pslverr;
   } apb_rsp_t;

   typedef struct packed {
      logic reset_n;
      logic en_sa_boot;
      logic fetch_en;
   } cluster_ctrl_t;

   typedef struct packed {
      reg_data_t cache_addr_start;
      reg_data_t cache_addr_end;
      reg_data_t spm_addr_start;
   } llc_cfg_t;

   typedef struct packed {
      clk_sel_t  sel;
      reg_data_t div;
      logic      div_qe;
      logic      gate_en;
   } clk_ctrl_t;

   typedef struct packed {
      logic read_hit;
      logic read_miss;
      logic write_hit;
      logic write_miss;
   } llc_events_t;

   typedef struct packed {
      llc_count_t read_hit;
      llc_count_t read_miss;
      llc_count_t write_hit;
      llc_count_t write_miss;
   } llc_counts_t;

   // reset values leave the cluster held in reset with fetch disabled
   localparam reg_data_t     CLK_DIV_RESET      = 32'd1;
   localparam cluster_ctrl_t CLUSTER_CTRL_RESET = '0;
   localparam llc_cfg_t      LLC_CFG_RESET      = '0;
   localparam logic          COUNT_EN_RESET     = 1'b0;
   localparam clk_ctrl_t     CLK_CTRL_RESET     = '{
      sel:     '0,
      div:     CLK_DIV_RESET,
      div_qe:  1'b0,
      gate_en: 1'b0
   };

endpackage

//--- hdl/soc_ctrl_regs.sv
/* APB slave with the control register file; no wait states, pready follows the access phase
   unmapped offsets and writes to counters give pslverr with read data zero */
`timescale 1ns/1ps

module soc_ctrl_regs (
   input  logic                        clk_i,
   input  logic                        reset_i,
   input  soc_ctrl_pkg::apb_req_t      apb_req_i,
   output soc_ctrl_pkg::apb_rsp_t      apb_rsp_o,
   input  soc_ctrl_pkg::llc_counts_t   llc_counts_i,
   output logic                        count_en_o,
   output soc_ctrl_pkg::cluster_ctrl_t cluster_ctrl_o,
   output soc_ctrl_pkg::llc_cfg_t      llc_cfg_o,
   output soc_ctrl_pkg::clk_ctrl_t     clk_ctrl_o
);
   import soc_ctrl_pkg::*;

   logic          access;
   logic          wr_access;
   logic          rd_access;
   reg_idx_t      reg_idx;
   reg_data_t     wdata;
   reg_data_t     rdata;
   logic          ofs_valid;
   logic          ofs_counter;

   // one write strobe per writable register
   logic          wr_cluster;
   logic          wr_cache_start;
   logic          wr_cache_end;
   logic          wr_spm_start;
   logic          wr_cnt_en;
   logic          wr_clk_sel;
   logic          wr_clk_div;
   logic          wr_clk_gate;

   cluster_ctrl_t cluster_q;
   llc_cfg_t      llc_cfg_q;
   logic          count_en_q;
   clk_ctrl_t     clk_ctrl_q;

   // the transfer completes in its access phase since pready is never held low
   assign access    = apb_req_i.psel & apb_req_i.penable;
   assign wr_access = access & apb_req_i.pwrite;
   assign rd_access = access & ~apb_req_i.pwrite;
   assign reg_idx   = apb_req_i.paddr[REG_IDX_LSB +: REG_IDX_W];
   assign wdata     = apb_req_i.pwdata;

   // address decode, write strobes and read mux share one case
   always_comb begin
      ofs_valid      = 1'b1;
      ofs_counter    = 1'b0;
      rdata          = '0;
      wr_cluster     = 1'b0;
      wr_cache_start = 1'b0;
      wr_cache_end   = 1'b0;
      wr_spm_start   = 1'b0;
      wr_cnt_en      = 1'b0;
      wr_clk_sel     = 1'b0;
      wr_clk_div     = 1'b0;
      wr_clk_gate    = 1'b0;
      case (reg_idx)
         CTRL_CLUSTER_OFS[REG_IDX_LSB +: REG_IDX_W]: begin
            wr_cluster                    = wr_access;
            rdata[CLUSTER_RESET_N_BIT]    = cluster_q.reset_n;
            rdata[CLUSTER_EN_SA_BOOT_BIT] = cluster_q.en_sa_boot;
            rdata[CLUSTER_FETCH_EN_BIT]   = cluster_q.fetch_en;
         end
         LLC_CACHE_START_OFS[REG_IDX_LSB +: REG_IDX_W]: begin
            wr_cache_start = wr_access;
            rdata          = llc_cfg_q.cache_addr_start;
         end
         LLC_CACHE_END_OFS[REG_IDX_LSB +: REG_IDX_W]: begin
            wr_cache_end = wr_access;
            rdata        = llc_cfg_q.cache_addr_end;
         end
         LLC_SPM_START_OFS[REG_IDX_LSB +: REG_IDX_W]: begin
            wr_spm_start = wr_access;
            rdata        = llc_cfg_q.spm_addr_start;
         end
         LLC_CNT_EN_OFS[REG_IDX_LSB +: REG_IDX_W]: begin
            wr_cnt_en         = wr_access;
            rdata[CNT_EN_BIT] = count_en_q;
         end
         CLK_SEL_OFS[REG_IDX_LSB +: REG_IDX_W]: begin
            wr_clk_sel             = wr_access;
            rdata[CLK_SEL_W-1:0]   = clk_ctrl_q.sel;
         end
         CLK_DIV_OFS[REG_IDX_LSB +: REG_IDX_W]: begin
            wr_clk_div = wr_access;
            rdata      = clk_ctrl_q.div;
         end
         CLK_GATE_OFS[REG_IDX_LSB +: REG_IDX_W]: begin
            wr_clk_gate            = wr_access;
            rdata[CLK_GATE_EN_BIT] = clk_ctrl_q.gate_en;
         end
         READ_HIT_OFS[REG_IDX_LSB +: REG_IDX_W]: begin
            ofs_counter = 1'b1;
            rdata       = llc_counts_i.read_hit;
         end
         READ_MISS_OFS[REG_IDX_LSB +: REG_IDX_W]: begin
            ofs_counter = 1'b1;
            rdata       = llc_counts_i.read_miss;
         end
         WRITE_HIT_OFS[REG_IDX_LSB +: REG_IDX_W]: begin
            ofs_counter = 1'b1;
            rdata       = llc_counts_i.write_hit;
         end
         WRITE_MISS_OFS[REG_IDX_LSB +: REG_IDX_W]: begin
            ofs_counter = 1'b1;
            rdata       = llc_counts_i.write_miss;
         end
         default: begin
            ofs_valid = 1'b0;
         end
      endcase
   end

   // cluster control and LLC address window
   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         cluster_q  <= CLUSTER_CTRL_RESET;
         llc_cfg_q  <= LLC_CFG_RESET;
         count_en_q <= COUNT_EN_RESET;
      end else begin
         if (wr_cluster) begin
            cluster_q.reset_n    <= wdata[CLUSTER_RESET_N_BIT];
            cluster_q.en_sa_boot <= wdata[CLUSTER_EN_SA_BOOT_BIT];
            cluster_q.fetch_en   <= wdata[CLUSTER_FETCH_EN_BIT];
         end
         if (wr_cache_start) begin
            llc_cfg_q.cache_addr_start <= wdata;
         end
         if (wr_cache_end) begin
            llc_cfg_q.cache_addr_end <= wdata;
         end
         if (wr_spm_start) begin
            llc_cfg_q.spm_addr_start <= wdata;
         end
         if (wr_cnt_en) begin
            count_en_q <= wdata[CNT_EN_BIT];
         end
      end
   end

   // external clock mux, divider and gate
   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         clk_ctrl_q <= CLK_CTRL_RESET;
      end else begin
         if (wr_clk_sel) begin
            clk_ctrl_q.sel <= wdata[CLK_SEL_W-1:0];
         end
         if (wr_clk_div) begin
            clk_ctrl_q.div <= wdata;
         end
         if (wr_clk_gate) begin
            clk_ctrl_q.gate_en <= wdata[CLK_GATE_EN_BIT];
         end
         // the divider sees its new value together with this one-cycle qualifier
         clk_ctrl_q.div_qe <= wr_clk_div;
      end
   end

   assign apb_rsp_o.pready  = access;
   assign apb_rsp_o.pslverr = access & (~ofs_valid | (apb_req_i.pwrite & ofs_counter));
   assign apb_rsp_o.prdata  = rd_access ? rdata : '0;

   assign count_en_o     = count_en_q;
   assign cluster_ctrl_o = cluster_q;
   assign llc_cfg_o      = llc_cfg_q;
   assign clk_ctrl_o     = clk_ctrl_q;

endmodule

//--- hdl/soc_ctrl_top.sv
/* SoC control and status block on APB: cluster boot control, LLC window,
   clock controls and LLC event counters */
`timescale 1ns/1ps

module soc_ctrl_top (
   input  logic                        clk_i,
   input  logic                        reset_i,
   input  soc_ctrl_pkg::apb_req_t      apb_req_i,
   output soc_ctrl_pkg::apb_rsp_t      apb_rsp_o,
   input  soc_ctrl_pkg::llc_events_t   llc_events_i,
   output soc_ctrl_pkg::cluster_ctrl_t cluster_ctrl_o,
   output soc_ctrl_pkg::llc_cfg_t      llc_cfg_o,
   output soc_ctrl_pkg::clk_ctrl_t     clk_ctrl_o
);
   import soc_ctrl_pkg::*;

   // counter values go back to the register file for read-out
   llc_counts_t llc_counts;
   logic        count_en;

   soc_ctrl_regs i_soc_ctrl_regs (
      .clk_i          ( clk_i          ),
      .reset_i        ( reset_i        ),
      .apb_req_i      ( apb_req_i      ),
      .apb_rsp_o      ( apb_rsp_o      ),
      .llc_counts_i   ( llc_counts     ),
      .count_en_o     ( count_en       ),
      .cluster_ctrl_o ( cluster_ctrl_o ),
      .llc_cfg_o      ( llc_cfg_o      ),
      .clk_ctrl_o     ( clk_ctrl_o     )
   );

   // the enable is registered, so it gates events from the cycle after its write
   llc_event_counters i_llc_event_counters (
      .clk_i      ( clk_i        ),
      .reset_i    ( reset_i      ),
      .count_en_i ( count_en     ),
      .events_i   ( llc_events_i ),
      .counts_o   ( llc_counts   )
   );

endmodule

//--- run_sim.sh
#!/bin/sh
# build the simulation with Verilator, run it and look for the pass line in its output
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f build.f --top-module soc_ctrl_tb -o soc_ctrl_sim \
   || { echo "build failed"; exit 1; }
out=$(./obj_dir/soc_ctrl_sim 2>&1)
echo "$out"
echo "$out" | grep -qx "Finished with no errors" \
   && echo "simulation passed" \
   || { echo "simulation failed"; exit 1; }

//--- tb/soc_ctrl_properties.sv
/* APB handshake and divider qualifier assertions, bound into soc_ctrl_top
   checks are off while reset_i is high, fail_count totals the failures */
`timescale 1ns/1ps

module soc_ctrl_properties (
   input logic                    clk_i,
   input logic                    reset_i,
   input soc_ctrl_pkg::apb_req_t  apb_req_i,
   input soc_ctrl_pkg::apb_rsp_t  apb_rsp_i,
   input soc_ctrl_pkg::clk_ctrl_t clk_ctrl_i
);
   import soc_ctrl_pkg::*;

   int unsigned fail_count = 0;
   logic        access;
   logic        div_write;

   assign access    = apb_req_i.psel & apb_req_i.penable;
   assign div_write = access & apb_req_i.pwrite &
                      (apb_req_i.paddr[7:2] == CLK_DIV_OFS[7:2]);

   pready_in_access: assert property (@(posedge clk_i) disable iff (reset_i)
      apb_rsp_i.pready |-> access)
      else begin
         fail_count++;
         $error("pready high outside the access phase");
      end

   div_qe_one_cycle: assert property (@(posedge clk_i) disable iff (reset_i)
      clk_ctrl_i.div_qe |=> !clk_ctrl_i.div_qe)
      else begin
         fail_count++;
         $error("div_qe high for more than one cycle");
      end

   // the qualifier is registered from the access-phase write strobe
   div_qe_after_write: assert property (@(posedge clk_i) disable iff (reset_i)
      clk_ctrl_i.div_qe |-> $past(div_write))
      else begin
         fail_count++;
         $error("div_qe without a preceding divider write");
      end

   pslverr_in_access: assert property (@(posedge clk_i) disable iff (reset_i)
      apb_rsp_i.pslverr |-> access)
      else begin
         fail_count++;
         $error("pslverr high outside the access phase");
      end

endmodule

bind soc_ctrl_top soc_ctrl_properties i_soc_ctrl_properties (
   .clk_i      ( clk_i      ),
   .reset_i    ( reset_i    ),
   .apb_req_i  ( apb_req_i  ),
   .apb_rsp_i  ( apb_rsp_o  ),
   .clk_ctrl_i ( clk_ctrl_o )
);

//--- tb/soc_ctrl_tb.sv
/* testbench for soc_ctrl_top with random APB traffic and random LLC events
   inputs change on the falling edge and outputs are sampled 1 ns after it */
`timescale 1ns/1ps

module soc_ctrl_tb;
   import soc_ctrl_pkg::*;

   localparam int unsigned CLK_HALF       = 4;
   localparam int unsigned RESET_CYCLES   = 4;
   localparam int unsigned PREADY_TIMEOUT = 16;
   localparam int unsigned NUM_WRITES     = 60;
   localparam int unsigned NUM_CNT_ROUNDS = 24;
   localparam int unsigned NUM_ERR        = 16;

   logic          clk;
   logic          reset;
   apb_req_t      apb_req;
   apb_rsp_t      apb_rsp;
   llc_events_t   llc_events;
   cluster_ctrl_t cluster_ctrl;
   llc_cfg_t      llc_cfg;
   clk_ctrl_t     clk_ctrl;
   integer        seed;
   logic          ev_run;

   // model of the writable fields and of the four counters
   cluster_ctrl_t m_cluster;
   llc_cfg_t      m_cfg;
   clk_sel_t      m_sel;
   reg_data_t     m_div;
   logic          m_gate;
   logic          m_cnt_en;
   llc_count_t    m_cnt [4];

   soc_ctrl_top i_soc_ctrl_top (
      .clk_i          ( clk          ),
      .reset_i        ( reset        ),
      .apb_req_i      ( apb_req      ),
      .apb_rsp_o      ( apb_rsp      ),
      .llc_events_i   ( llc_events   ),
      .cluster_ctrl_o ( cluster_ctrl ),
      .llc_cfg_o      ( llc_cfg      ),
      .clk_ctrl_o     ( clk_ctrl     )
   );

   initial begin
      clk = 1'b0;
      forever #CLK_HALF clk = ~clk;
   end

   function automatic reg_data_t rand_word();
      return $random(seed);
   endfunction

   function automatic int unsigned rand_below(input int unsigned n);
      return rand_word() % n;
   endfunction

   // the word index goes to bits 7:2 and the undecoded bits are random
   function automatic apb_addr_t make_addr(input int unsigned idx);
      reg_data_t r;
      r = rand_word();
      return {r[31:8], idx[5:0], r[1:0]};
   endfunction

   function automatic reg_data_t expected_read(input apb_addr_t ofs);
      case (ofs)
         CTRL_CLUSTER_OFS:
            return {29'b0, m_cluster.fetch_en, m_cluster.en_sa_boot, m_cluster.reset_n};
         LLC_CACHE_START_OFS: return m_cfg.cache_addr_start;
         LLC_CACHE_END_OFS:   return m_cfg.cache_addr_end;
         LLC_SPM_START_OFS:   return m_cfg.spm_addr_start;
         LLC_CNT_EN_OFS:      return {31'b0, m_cnt_en};
         CLK_SEL_OFS:         return {30'b0, m_sel};
         CLK_DIV_OFS:         return m_div;
         CLK_GATE_OFS:        return {31'b0, m_gate};
         READ_HIT_OFS:        return m_cnt[0];
         READ_MISS_OFS:       return m_cnt[1];
         WRITE_HIT_OFS:       return m_cnt[2];
         WRITE_MISS_OFS:      return m_cnt[3];
         default:             return '0;
      endcase
   endfunction

   // the counter enable is tracked by the model process on the bus itself
   function automatic void apply_write(input apb_addr_t ofs, input reg_data_t data);
      case (ofs)
         CTRL_CLUSTER_OFS: begin
            m_cluster.reset_n    = data[0];
            m_cluster.en_sa_boot = data[1];
            m_cluster.fetch_en   = data[2];
         end
         LLC_CACHE_START_OFS: m_cfg.cache_addr_start = data;
         LLC_CACHE_END_OFS:   m_cfg.cache_addr_end = data;
         LLC_SPM_START_OFS:   m_cfg.spm_addr_start = data;
         CLK_SEL_OFS:         m_sel = data[1:0];
         CLK_DIV_OFS:         m_div = data;
         CLK_GATE_OFS:        m_gate = data[0];
         default: begin
         end
      endcase
   endfunction

   task automatic check_value(input string name, input reg_data_t actual,
                              input reg_data_t expected);
      if (actual !== expected) begin
         $display("** Error at %0t: %s is %0h, expected %0h", $time, name, actual, expected);
         $display("Finished with errors");
         $fatal(1, "value mismatch");
      end
   endtask

   task automatic check_ports(input logic exp_div_qe);
      check_value("cluster_ctrl_o.reset_n", reg_data_t'(cluster_ctrl.reset_n),
                  reg_data_t'(m_cluster.reset_n));
      check_value("cluster_ctrl_o.en_sa_boot", reg_data_t'(cluster_ctrl.en_sa_boot),
                  reg_data_t'(m_cluster.en_sa_boot));
      check_value("cluster_ctrl_o.fetch_en", reg_data_t'(cluster_ctrl.fetch_en),
                  reg_data_t'(m_cluster.fetch_en));
      check_value("llc_cfg_o.cache_addr_start", llc_cfg.cache_addr_start, m_cfg.cache_addr_start);
      check_value("llc_cfg_o.cache_addr_end", llc_cfg.cache_addr_end, m_cfg.cache_addr_end);
      check_value("llc_cfg_o.spm_addr_start", llc_cfg.spm_addr_start, m_cfg.spm_addr_start);
      check_value("clk_ctrl_o.sel", reg_data_t'(clk_ctrl.sel), reg_data_t'(m_sel));
      check_value("clk_ctrl_o.div", clk_ctrl.div, m_div);
      check_value("clk_ctrl_o.gate_en", reg_data_t'(clk_ctrl.gate_en), reg_data_t'(m_gate));
      check_value("clk_ctrl_o.div_qe", reg_data_t'(clk_ctrl.div_qe), reg_data_t'(exp_div_qe));
   endtask

   // one transfer followed by an idle cycle in which the ports are checked
   task automatic apb_access(input apb_addr_t addr, input logic write, input reg_data_t wdata);
      apb_addr_t   ofs;
      logic        exp_err;
      int unsigned wait_cycles;
      ofs = {24'h0, addr[7:2], 2'b00};
      exp_err = (ofs > WRITE_MISS_OFS) || (write && ofs >= READ_HIT_OFS);
      wait_cycles = 0;
      @(negedge clk);
      apb_req.paddr   = addr;
      apb_req.psel    = 1'b1;
      apb_req.penable = 1'b0;
      apb_req.pwrite  = write;
      apb_req.pwdata  = wdata;
      #1;
      check_value("apb_rsp_o.pready", reg_data_t'(apb_rsp.pready), '0);
      check_value("apb_rsp_o.pslverr", reg_data_t'(apb_rsp.pslverr), '0);
      check_value("clk_ctrl_o.div_qe", reg_data_t'(clk_ctrl.div_qe), '0);
      @(negedge clk);
      apb_req.penable = 1'b1;
      #1;
      while (apb_rsp.pready !== 1'b1) begin
         if (wait_cycles == PREADY_TIMEOUT) begin
            $display("pready stayed low for %0d cycles, address %0h", PREADY_TIMEOUT, addr);
            $display("Finished with errors");
            $fatal(1, "APB transfer timed out");
         end
         @(negedge clk);
         #1;
         wait_cycles++;
      end
      check_value("apb_rsp_o.pslverr", reg_data_t'(apb_rsp.pslverr), reg_data_t'(exp_err));
      check_value("clk_ctrl_o.div_qe", reg_data_t'(clk_ctrl.div_qe), '0);
      if (!write) begin
         check_value("apb_rsp_o.prdata", apb_rsp.prdata, expected_read(ofs));
      end
      @(negedge clk);
      apb_req.psel    = 1'b0;
      apb_req.penable = 1'b0;
      if (write && !exp_err) begin
         apply_write(ofs, wdata);
      end
      #1;
      check_ports(write && !exp_err && ofs == CLK_DIV_OFS);
   endtask

   // events are gated by the enable as it stood before each edge
   always @(posedge clk) begin
      if (reset) begin
         m_cnt_en = 1'b0;
         for (int i = 0; i < 4; i++) begin
            m_cnt[i] = '0;
         end
      end else begin
         if (m_cnt_en) begin
            m_cnt[0] = m_cnt[0] + llc_count_t'(llc_events.read_hit);
            m_cnt[1] = m_cnt[1] + llc_count_t'(llc_events.read_miss);
            m_cnt[2] = m_cnt[2] + llc_count_t'(llc_events.write_hit);
            m_cnt[3] = m_cnt[3] + llc_count_t'(llc_events.write_miss);
         end
         if (apb_req.psel && apb_req.penable && apb_req.pwrite &&
             apb_req.paddr[7:2] == LLC_CNT_EN_OFS[7:2]) begin
            m_cnt_en = apb_req.pwdata[0];
         end
      end
   end

   initial begin
      reg_data_t r;
      llc_events = '0;
      forever begin
         @(negedge clk);
         r = rand_word();
         llc_events = ev_run ? llc_events_t'(r[3:0]) : '0;
      end
   end

   initial begin
      int unsigned idx;
      reg_data_t   data;
      seed      = 32'h74ca;
      reset     = 1'b1;
      apb_req   = '0;
      ev_run    = 1'b0;
      m_cluster = '0;
      m_cfg     = '0;
      m_sel     = '0;
      m_div     = CLK_DIV_RESET;
      m_gate    = 1'b0;
      repeat (RESET_CYCLES) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;
      #1;
      check_ports(1'b0);
      for (int i = 0; i < 12; i++) begin
         apb_access(make_addr(i), 1'b0, '0);
      end
      repeat (NUM_WRITES) begin
         idx  = rand_below(8);
         data = rand_word();
         apb_access(make_addr(idx), 1'b1, data);
         apb_access(make_addr(idx), 1'b0, '0);
      end
      // counters run against random events while the enable flips
      ev_run = 1'b1;
      repeat (NUM_CNT_ROUNDS) begin
         apb_access(LLC_CNT_EN_OFS, 1'b1, rand_word());
         repeat (rand_below(8)) @(negedge clk);
         apb_access(LLC_CNT_EN_OFS, 1'b0, '0);
         for (int i = 8; i < 12; i++) begin
            apb_access(make_addr(i), 1'b0, '0);
         end
      end
      repeat (NUM_ERR) begin
         data = rand_word();
         apb_access(make_addr(12 + rand_below(52)), data[0], rand_word());
         apb_access(make_addr(8 + rand_below(4)), 1'b1, rand_word());
      end
      for (int i = 0; i < 12; i++) begin
         apb_access(make_addr(i), 1'b0, '0);
      end
      if (i_soc_ctrl_top.i_soc_ctrl_properties.fail_count == 0) begin
         $display("Finished with no errors");
         $finish;
      end else begin
         $display("bound assertions failed %0d times",
                  i_soc_ctrl_top.i_soc_ctrl_properties.fail_count);
         $display("Finished with errors");
         $fatal(1, "assertion failures");
      end
   end

endmodule
